// File: hazard_pkg.sv
`default_nettype none

package hazard_pkg;

    // ======================================================================
    // register address and instruction word.
    // ======================================================================
    typedef logic [4:0] reg_addr_t;

    // the same 32 bits, seen as register-register or as immediate format.
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12; // bits 24:20 are immediate here, not rs2.
            reg_addr_t   rs1;
            logic [2:0]  funct3;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } i;
    } inst_word_u;

    // ======================================================================
    // rv64i major opcodes used by the decoder.
    // ======================================================================
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    // forwarding source for one id operand.
    typedef enum logic [1:0] {
        fwd_none = 2'd0, // value from the register file.
        fwd_ex   = 2'd1,
        fwd_mem  = 2'd2,
        fwd_wb   = 2'd3
    } fwd_sel_t;

endpackage

`default_nettype wire

// File: inst_field_decode.sv
`default_nettype none

module inst_field_decode
    import hazard_pkg::*;
(
    input  logic [31:0] issue_inst,
    input  logic        issue_valid,
    output reg_addr_t   id_rs1,
    output reg_addr_t   id_rs2,
    output logic        id_uses_rs1,
    output logic        id_uses_rs2,
    output reg_addr_t   id_rd,
    output logic        id_writes_rd,
    output logic        id_is_load
);

    inst_word_u inst;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       writes_rd;
    logic       is_load;

    assign inst = issue_inst;

    // ======================================================================
    // opcode classification.
    // ======================================================================
    always_comb begin
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        is_load   = 1'b0;
        case (inst.r.opcode)
            opc_op: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                writes_rd = 1'b1;
            end
            opc_op_imm: begin
                uses_rs1  = 1'b1; // imm12 covers bits 24:20.
                writes_rd = 1'b1;
            end
            opc_load: begin
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
                is_load   = 1'b1;
            end
            opc_store, opc_branch: begin
                // rd field carries immediate bits here.
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
            end
            opc_lui, opc_jal: begin
                writes_rd = 1'b1;
            end
            default: begin
                uses_rs1  = 1'b0; // unknown opcodes take no part in hazards.
            end
        endcase
    end

    // register fields. rs2 only means something in the r view.
    assign id_rs1 = inst.i.rs1;
    assign id_rs2 = inst.r.rs2;
    assign id_rd  = inst.i.rd;

    // ======================================================================
    // qualified flags.
    // ======================================================================
    assign id_uses_rs1  = issue_valid & uses_rs1;
    assign id_uses_rs2  = issue_valid & uses_rs2;
    assign id_writes_rd = issue_valid & writes_rd & (inst.i.rd != 5'd0); // x0 is never written.
    assign id_is_load   = issue_valid & is_load;

endmodule

`default_nettype wire

// File: stage_dest_track.sv
`default_nettype none

module stage_dest_track
    import hazard_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t id_rd,
    input  logic      id_writes_rd,
    input  logic      id_is_load,
    input  logic      issue_valid,
    input  logic      stall_id,
    output reg_addr_t ex_rd,
    output logic      ex_wr,
    output logic      ex_load,
    output reg_addr_t mem_rd,
    output logic      mem_wr,
    output reg_addr_t wb_rd,
    output logic      wb_wr
);

    logic advance; // id instruction moves into ex this edge.

    assign advance = issue_valid & ~stall_id;

    // ======================================================================
    // control flags. a bubble enters ex when nothing advances.
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_wr   <= 1'b0;
            ex_load <= 1'b0;
            mem_wr  <= 1'b0;
            wb_wr   <= 1'b0;
        end else begin
            if (advance) begin
                ex_wr   <= id_writes_rd;
                ex_load <= id_is_load;
            end else begin
                ex_wr   <= 1'b0;
                ex_load <= 1'b0;
            end
            mem_wr <= ex_wr;
            wb_wr  <= mem_wr;
        end
    end

    // ======================================================================
    // destination tags.
    // ======================================================================
    // tags are only looked at together with their write flag.
    always_ff @(posedge clk) begin
        ex_rd  <= id_rd;
        mem_rd <= ex_rd;
        wb_rd  <= mem_rd;
    end

endmodule

`default_nettype wire

// File: id_hazard_detect.sv
`default_nettype none

module id_hazard_detect
    import hazard_pkg::*;
(
    input  reg_addr_t id_rs1,
    input  reg_addr_t id_rs2,
    input  logic      id_uses_rs1,
    input  logic      id_uses_rs2,
    input  reg_addr_t ex_rd,
    input  reg_addr_t mem_rd,
    input  reg_addr_t wb_rd,
    input  logic      ex_wr,
    input  logic      ex_load,
    input  logic      mem_wr,
    input  logic      wb_wr,
    output logic      stall_id,
    output fwd_sel_t  fwd_rs1_sel,
    output fwd_sel_t  fwd_rs2_sel
);

    logic rs1_hit_ex;
    logic rs1_hit_mem;
    logic rs1_hit_wb;
    logic rs2_hit_ex;
    logic rs2_hit_mem;
    logic rs2_hit_wb;
    logic load_use;

    // youngest writer first.
    function automatic fwd_sel_t pick_src(input logic hit_ex, input logic hit_mem,
                                          input logic hit_wb);
        fwd_sel_t sel;
        if (hit_ex) begin
            sel = fwd_ex;
        end else if (hit_mem) begin
            sel = fwd_mem;
        end else if (hit_wb) begin
            sel = fwd_wb;
        end else begin
            sel = fwd_none;
        end
        return sel;
    endfunction

    // ======================================================================
    // tag compares. x0 writers already carry a cleared write flag.
    // ======================================================================
    assign rs1_hit_ex  = id_uses_rs1 & ex_wr  & (id_rs1 == ex_rd);
    assign rs1_hit_mem = id_uses_rs1 & mem_wr & (id_rs1 == mem_rd);
    assign rs1_hit_wb  = id_uses_rs1 & wb_wr  & (id_rs1 == wb_rd);

    assign rs2_hit_ex  = id_uses_rs2 & ex_wr  & (id_rs2 == ex_rd);
    assign rs2_hit_mem = id_uses_rs2 & mem_wr & (id_rs2 == mem_rd);
    assign rs2_hit_wb  = id_uses_rs2 & wb_wr  & (id_rs2 == wb_rd);

    // ======================================================================
    // load-use stall and forward selects.
    // ======================================================================
    // load data only exists after mem, so an ex match must wait a cycle.
    assign load_use = ex_load & (rs1_hit_ex | rs2_hit_ex);
    assign stall_id = load_use;

    always_comb begin
        if (load_use) begin
            fwd_rs1_sel = fwd_none; // instruction is held in id.
            fwd_rs2_sel = fwd_none;
        end else begin
            fwd_rs1_sel = pick_src(rs1_hit_ex, rs1_hit_mem, rs1_hit_wb);
            fwd_rs2_sel = pick_src(rs2_hit_ex, rs2_hit_mem, rs2_hit_wb);
        end
    end

endmodule

`default_nettype wire

// File: hazard_top.sv
`default_nettype none

module hazard_top
    import hazard_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        issue_valid,
    input  logic [31:0] issue_inst,
    output logic        stall_id,
    output fwd_sel_t    fwd_rs1_sel,
    output fwd_sel_t    fwd_rs2_sel
);

    // id stage fields.
    reg_addr_t id_rs1;
    reg_addr_t id_rs2;
    reg_addr_t id_rd;
    logic      id_uses_rs1;
    logic      id_uses_rs2;
    logic      id_writes_rd;
    logic      id_is_load;

    // in-flight destinations.
    reg_addr_t ex_rd;
    reg_addr_t mem_rd;
    reg_addr_t wb_rd;
    logic      ex_wr;
    logic      ex_load;
    logic      mem_wr;
    logic      wb_wr;

    // ======================================================================
    // decode, track, detect.
    // ======================================================================
    inst_field_decode u_decode (
        .issue_inst   (issue_inst),
        .issue_valid  (issue_valid),
        .id_rs1       (id_rs1),
        .id_rs2       (id_rs2),
        .id_uses_rs1  (id_uses_rs1),
        .id_uses_rs2  (id_uses_rs2),
        .id_rd        (id_rd),
        .id_writes_rd (id_writes_rd),
        .id_is_load   (id_is_load)
    );

    stage_dest_track u_track (
        .clk          (clk),
        .rst_n        (rst_n),
        .id_rd        (id_rd),
        .id_writes_rd (id_writes_rd),
        .id_is_load   (id_is_load),
        .issue_valid  (issue_valid),
        .stall_id     (stall_id),
        .ex_rd        (ex_rd),
        .ex_wr        (ex_wr),
        .ex_load      (ex_load),
        .mem_rd       (mem_rd),
        .mem_wr       (mem_wr),
        .wb_rd        (wb_rd),
        .wb_wr        (wb_wr)
    );

    id_hazard_detect u_detect (
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .id_uses_rs1 (id_uses_rs1),
        .id_uses_rs2 (id_uses_rs2),
        .ex_rd       (ex_rd),
        .mem_rd      (mem_rd),
        .wb_rd       (wb_rd),
        .ex_wr       (ex_wr),
        .ex_load     (ex_load),
        .mem_wr      (mem_wr),
        .wb_wr       (wb_wr),
        .stall_id    (stall_id),
        .fwd_rs1_sel (fwd_rs1_sel),
        .fwd_rs2_sel (fwd_rs2_sel)
    );

endmodule

`default_nettype wire

// File: tb_hazard_top.sv
`default_nettype none

module tb_hazard_top
    import hazard_pkg::*;
();

    localparam int clk_period = 8;
    localparam int rand_count = 300;

    logic        clk;
    logic        rst_n;
    logic        issue_valid;
    logic [31:0] issue_inst;
    logic        stall_id;
    fwd_sel_t    fwd_rs1_sel;
    fwd_sel_t    fwd_rs2_sel;

    // directed table with one row per cycle.
    string       row_name[$];
    logic [31:0] row_inst[$];
    logic        row_valid[$];
    logic        row_stall[$];
    fwd_sel_t    row_rs1[$];
    fwd_sel_t    row_rs2[$];

    reg_addr_t   ref_rd[3]; // index 0 is ex, 1 is mem, 2 is wb.
    logic        ref_wr[3];
    logic        ref_load;
    logic [31:0] lcg_state;

    hazard_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_inst  (issue_inst),
        .stall_id    (stall_id),
        .fwd_rs1_sel (fwd_rs1_sel),
        .fwd_rs2_sel (fwd_rs2_sel)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ======================================================================
    // instruction builders and random source.
    // ======================================================================
    function automatic logic [31:0] make_r(input logic [6:0] opc, input reg_addr_t rd,
                                           input reg_addr_t rs1, input reg_addr_t rs2);
        inst_word_u w;
        w          = '0;
        w.r.opcode = opc;
        w.r.rd     = rd;
        w.r.rs1    = rs1;
        w.r.rs2    = rs2;
        return w;
    endfunction

    function automatic logic [31:0] make_i(input logic [6:0] opc, input reg_addr_t rd,
                                           input reg_addr_t rs1, input logic [11:0] imm12);
        inst_word_u w;
        w          = '0;
        w.i.opcode = opc;
        w.i.rd     = rd;
        w.i.rs1    = rs1;
        w.i.imm12  = imm12;
        return w;
    endfunction

    function automatic logic [31:0] alu(input reg_addr_t rd, input reg_addr_t rs1,
                                        input reg_addr_t rs2);
        return make_r(opc_op, rd, rs1, rs2);
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic random_inst(output logic [31:0] inst, output logic valid);
        logic [6:0] opc;
        lcg_state = lcg_next(lcg_state);
        case (lcg_state[18:16])
            3'd0:       opc = opc_op;
            3'd1:       opc = opc_op_imm;
            3'd2, 3'd3: opc = opc_load; // loads twice as often to provoke load-use stalls.
            3'd4:       opc = opc_store;
            3'd5:       opc = opc_branch;
            3'd6:       opc = opc_lui;
            default:    opc = opc_jal;
        endcase
        // only x0 to x3 so that hazards are frequent.
        inst  = make_r(opc, {3'b000, lcg_state[21:20]}, {3'b000, lcg_state[23:22]},
                       {3'b000, lcg_state[25:24]});
        valid = (lcg_state[29:27] != 3'd0);
    endtask

    // ======================================================================
    // reference model of decode, tag chain and hazard rules.
    // ======================================================================
    task automatic classify(input logic [6:0] opc, output logic u1, output logic u2,
                            output logic wr, output logic ld);
        u1 = opc inside {opc_op, opc_op_imm, opc_load, opc_store, opc_branch};
        u2 = opc inside {opc_op, opc_store, opc_branch};
        wr = opc inside {opc_op, opc_op_imm, opc_load, opc_lui, opc_jal};
        ld = (opc == opc_load);
    endtask

    // later checks override earlier ones, so the youngest writer wins.
    function automatic fwd_sel_t ref_pick(input logic used, input reg_addr_t rs);
        fwd_sel_t sel;
        sel = fwd_none;
        if (used && ref_wr[2] && ref_rd[2] == rs) sel = fwd_wb;
        if (used && ref_wr[1] && ref_rd[1] == rs) sel = fwd_mem;
        if (used && ref_wr[0] && ref_rd[0] == rs) sel = fwd_ex;
        return sel;
    endfunction

    task automatic ref_expect(input logic [31:0] inst, input logic valid, output logic stall,
                              output fwd_sel_t s1, output fwd_sel_t s2);
        inst_word_u w;
        logic       u1;
        logic       u2;
        logic       wr;
        logic       ld;
        w = inst;
        classify(w.r.opcode, u1, u2, wr, ld);
        s1    = ref_pick(valid & u1, w.r.rs1);
        s2    = ref_pick(valid & u2, w.r.rs2);
        stall = ref_load & ((s1 == fwd_ex) | (s2 == fwd_ex)); // load data not ready yet.
        if (stall) begin
            s1 = fwd_none;
            s2 = fwd_none;
        end
    endtask

    task automatic ref_advance(input logic [31:0] inst, input logic valid, input logic stall);
        inst_word_u w;
        logic       u1;
        logic       u2;
        logic       wr;
        logic       ld;
        w = inst;
        classify(w.r.opcode, u1, u2, wr, ld);
        ref_rd[2] = ref_rd[1];
        ref_wr[2] = ref_wr[1];
        ref_rd[1] = ref_rd[0];
        ref_wr[1] = ref_wr[0];
        ref_rd[0] = w.i.rd;
        ref_wr[0] = valid & ~stall & wr & (w.i.rd != 5'd0);
        ref_load  = valid & ~stall & ld;
    endtask

    // ======================================================================
    // stimulus and checks.
    // ======================================================================
    task automatic add_row(input string name, input logic [31:0] inst, input logic valid,
                           input logic stall, input fwd_sel_t s1, input fwd_sel_t s2);
        row_name.push_back(name);
        row_inst.push_back(inst);
        row_valid.push_back(valid);
        row_stall.push_back(stall);
        row_rs1.push_back(s1);
        row_rs2.push_back(s2);
    endtask

    task automatic apply(input logic [31:0] inst, input logic valid);
        @(posedge clk);
        issue_inst  <= inst;
        issue_valid <= valid;
        #(clk_period - 1); // sample just before the next edge.
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [1:0] exp, input logic [1:0] got);
        assert (got == exp) else begin
            $display("FAILED %s: %s expected %0d, actual %0d", name, what, exp, got);
            $display("CHECKS FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic check_outputs(input string name, input logic stall,
                                 input fwd_sel_t s1, input fwd_sel_t s2);
        check_value(name, "stall_id", {1'b0, stall}, {1'b0, stall_id});
        check_value(name, "fwd_rs1_sel", s1, fwd_rs1_sel);
        check_value(name, "fwd_rs2_sel", s2, fwd_rs2_sel);
    endtask

    initial begin
        logic [31:0] inst;
        logic        valid;
        logic        exp_stall;
        fwd_sel_t    exp_rs1;
        fwd_sel_t    exp_rs2;
        // a writer of x1 sits in id during reset and must leave no trace.
        issue_inst  <= alu(5'd1, 5'd2, 5'd3);
        issue_valid <= 1'b1;
        rst_n       <= 1'b0;
        lcg_state   = 32'd45;
        ref_rd      = '{default: 5'd0};
        ref_wr      = '{default: 1'b0};
        ref_load    = 1'b0;
        inst        = 32'd0;
        valid       = 1'b0;
        exp_stall   = 1'b0;

        add_row("idle_after_reset", 32'd0, 1'b0, 1'b0, fwd_none, fwd_none);
        add_row("wr_x5", alu(5'd5, 5'd1, 5'd2), 1'b1, 1'b0, fwd_none, fwd_none);
        add_row("fwd_ex_rs1", alu(5'd8, 5'd5, 5'd3), 1'b1, 1'b0, fwd_ex, fwd_none);
        add_row("wr_x5_b", alu(5'd5, 5'd1, 5'd2), 1'b1, 1'b0, fwd_none, fwd_none);
        add_row("gap_one", alu(5'd9, 5'd1, 5'd2), 1'b1, 1'b0, fwd_none, fwd_none);
        add_row("fwd_mem_rs1", alu(5'd10, 5'd5, 5'd3), 1'b1, 1'b0, fwd_mem, fwd_none);
        add_row("wr_x5_c", alu(5'd5, 5'd1, 5'd2), 1'b1, 1'b0, fwd_none, fwd_none);
        add_row("gap_two_a", alu(5'd12, 5'd1, 5'd2), 1'b1, 1'b0, fwd_none, fwd_none);
        add_row("gap_two_b", alu(5'd13, 5'd1, 5'd2), 1'b1, 1'b0, fwd_none, fwd_none);
        add_row("fwd_wb_rs1", alu(5'd14, 5'd5, 5'd3), 1'b1, 1'b0, fwd_wb, fwd_none);
        add_row("ld_x6", make_i(opc_load, 5'd6, 5'd1, 12'd0), 1'b1, 1'b0, fwd_none, fwd_none);
        add_row("ld_use_stall", alu(5'd15, 5'd2, 5'd6), 1'b1, 1'b1, fwd_none, fwd_none);
        add_row("ld_use_hold", alu(5'd15, 5'd2, 5'd6), 1'b1, 1'b0, fwd_none, fwd_mem);
        add_row("wr_x7_old", alu(5'd7, 5'd1, 5'd2), 1'b1, 1'b0, fwd_none, fwd_none);
        add_row("wr_x7_new", alu(5'd7, 5'd2, 5'd1), 1'b1, 1'b0, fwd_none, fwd_none);
        add_row("youngest_ex", alu(5'd16, 5'd7, 5'd7), 1'b1, 1'b0, fwd_ex, fwd_ex);
        add_row("valid_low", alu(5'd17, 5'd16, 5'd16), 1'b0, 1'b0, fwd_none, fwd_none);
        add_row("wr_x0", alu(5'd0, 5'd1, 5'd2), 1'b1, 1'b0, fwd_none, fwd_none);
        add_row("rd_x0", alu(5'd17, 5'd0, 5'd0), 1'b1, 1'b0, fwd_none, fwd_none);
        add_row("store_x18", make_r(opc_store, 5'd18, 5'd4, 5'd3), 1'b1, 1'b0,
                fwd_none, fwd_none);
        add_row("after_store", alu(5'd19, 5'd18, 5'd1), 1'b1, 1'b0, fwd_none, fwd_none);
        add_row("wr_x20", alu(5'd20, 5'd1, 5'd2), 1'b1, 1'b0, fwd_none, fwd_none);
        add_row("imm_bits_x20", make_i(opc_op_imm, 5'd21, 5'd1, {7'd0, 5'd20}), 1'b1, 1'b0,
                fwd_none, fwd_none);
        add_row("ld_x0", make_i(opc_load, 5'd0, 5'd1, 12'd0), 1'b1, 1'b0, fwd_none, fwd_none);
        add_row("rd_x0_after_ld", alu(5'd22, 5'd0, 5'd1), 1'b1, 1'b0, fwd_none, fwd_none);
        add_row("ld_x23", make_i(opc_load, 5'd23, 5'd1, 12'd0), 1'b1, 1'b0,
                fwd_none, fwd_none);
        add_row("imm_bits_ld", make_i(opc_op_imm, 5'd24, 5'd2, {7'd0, 5'd23}), 1'b1, 1'b0,
                fwd_none, fwd_none);
        add_row("rd_x23_mem", alu(5'd25, 5'd23, 5'd24), 1'b1, 1'b0, fwd_mem, fwd_ex);

        repeat (10) @(posedge clk);
        rst_n       <= 1'b1;
        issue_valid <= 1'b0;

        for (int i = 0; i < row_name.size(); i++) begin
            apply(row_inst[i], row_valid[i]);
            check_outputs(row_name[i], row_stall[i], row_rs1[i], row_rs2[i]);
            ref_advance(row_inst[i], row_valid[i], row_stall[i]);
        end

        // a stalled instruction is offered again unchanged.
        for (int n = 0; n < rand_count; n++) begin
            if (!exp_stall) begin
                random_inst(inst, valid);
            end
            ref_expect(inst, valid, exp_stall, exp_rs1, exp_rs2);
            apply(inst, valid);
            check_outputs($sformatf("random_%0d", n), exp_stall, exp_rs1, exp_rs2);
            ref_advance(inst, valid, exp_stall);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

    // watchdog sized from the table and the random phase.
    initial begin
        @(posedge clk);
        repeat (row_name.size() + rand_count + 20) @(posedge clk);
        $display("timeout: the run did not reach its end in time");
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: flist.f
hazard_pkg.sv
inst_field_decode.sv
stage_dest_track.sv
id_hazard_detect.sv
hazard_top.sv
tb_hazard_top.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_hazard_top -f flist.f \
    -o tb_hazard_top &&
./obj_dir/tb_hazard_top | tee /dev/stderr | grep -q "ALL CHECKS PASSED" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }
